// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the trace encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module trdb_tb -f trdb.f -o trdb_sim \
    && ./obj_dir/trdb_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== source/trdb_branch_map.sv ====
// collects branch outcomes into the branch map and count until a packet takes them
`timescale 1ns/100ps

module trdb_branch_map (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  logic              is_branch_i,
    input  logic              is_branch_taken_i,
    input  logic              flush_i, // a packet consumes the map this cycle
    input  logic              clear_i,
    output trdb_pkg::bcount_t branches_o,
    output trdb_pkg::bmap_t   branch_map_o,
    output logic              full_o
);

    trdb_pkg::bmap_t   map_q;
    trdb_pkg::bcount_t cnt_q;
    logic              cur_branch; // this instruction is a branch
    trdb_pkg::bmap_t   cur_bit;    // its outcome placed at the next free slot

    assign cur_branch = inst_valid_i && is_branch_i;
    assign cur_bit    = trdb_pkg::bmap_t'(cur_branch && !is_branch_taken_i) << cnt_q; // 1 = not taken

    // outputs already hold the current branch so its own packet carries it
    assign branches_o   = cnt_q + trdb_pkg::bcount_t'(cur_branch);
    assign branch_map_o = map_q | cur_bit;
    assign full_o       = (branches_o == trdb_pkg::bcount_t'(trdb_pkg::BMAP_LEN));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i || flush_i) begin
            map_q <= '0; // restarts empty, flushed bits went out with the packet
            cnt_q <= '0;
        end else if (cur_branch) begin
            map_q <= branch_map_o;
            cnt_q <= branches_o;
        end
    end

endmodule

// ==== source/trdb_cpu_pkg.sv ====
// traced hart widths and types, referenced by scoped name from the encoder rtl
package trdb_cpu_pkg;

    localparam int unsigned XLEN      = 32; // hart register and address width
    localparam int unsigned PRIV_LEN  = 2;  // u/s/m privilege encoding
    localparam int unsigned CAUSE_LEN = 5;  // mcause exception code bits kept in trap packets

    // instruction address of the retired instruction
    typedef logic [XLEN-1:0] iaddr_t;

    // privilege level the instruction retired in
    typedef logic [PRIV_LEN-1:0] priv_t;

    typedef logic [CAUSE_LEN-1:0] cause_t; // exception or interrupt code
    typedef logic [XLEN-1:0]      tval_t;  // trap value, faulting address or instruction

endpackage

// ==== source/trdb_packet_emitter.sv ====
// builds the payload and byte length of the selected packet and registers them for output
`timescale 1ns/100ps

module trdb_packet_emitter (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             emit_i,
    input  trdb_pkg::trdb_format_e           format_i,
    input  trdb_pkg::trdb_f_sync_subformat_e subformat_i,
    input  logic                             map_full_sel_i,
    input  trdb_cpu_pkg::iaddr_t             iaddr_i,
    input  trdb_cpu_pkg::priv_t              priv_i,
    input  trdb_cpu_pkg::cause_t             cause_i,
    input  trdb_cpu_pkg::tval_t              tval_i,
    input  logic                             interrupt_i,
    input  logic                             is_branch_i,
    input  logic                             is_branch_taken_i,
    input  trdb_pkg::bcount_t                branches_i,
    input  trdb_pkg::bmap_t                  branch_map_i,
    input  trdb_pkg::qual_status_e           qual_status_i,
    output logic                             packet_valid_o,
    output trdb_pkg::trdb_format_e           packet_format_o,
    output trdb_pkg::payload_t               packet_payload_o,
    output trdb_pkg::plen_t                  payload_length_o // bytes
);

    logic                         branch;      // 1 unless a taken branch
    logic                         addr_upd;    // packet carries an address
    trdb_cpu_pkg::iaddr_t         last_addr_q; // reference for format 1 deltas
    trdb_cpu_pkg::iaddr_t         diff_addr;
    logic [trdb_pkg::SUPPORT_W-1:0] support_f;
    logic [trdb_pkg::START_W-1:0]   start_f;
    logic [trdb_pkg::TRAP_W-1:0]    trap_f;
    logic [trdb_pkg::ADDR_W-1:0]    addr_f;
    logic [trdb_pkg::DIFF_W-1:0]    diff_f;
    logic [trdb_pkg::MAP_W-1:0]     map_f;
    trdb_pkg::payload_t           payload_d;
    trdb_pkg::plen_t              len_d;

    // bits rounded up to whole bytes
    function automatic trdb_pkg::plen_t bytes_of(input int unsigned nbits);
        return trdb_pkg::plen_t'((nbits + 7) / 8);
    endfunction

    assign branch    = !(is_branch_i && is_branch_taken_i);
    assign diff_addr = iaddr_i - last_addr_q;

    // field lists, format in the msbs
    assign support_f = {trdb_pkg::F_SYNC, trdb_pkg::SF_SUPPORT, 1'b1, 1'b0, // ienable, mode 0
                        qual_status_i, trdb_pkg::DELTA_ADDRESS};
    assign start_f   = {trdb_pkg::F_SYNC, trdb_pkg::SF_START, branch, priv_i, iaddr_i};
    assign trap_f    = {trdb_pkg::F_SYNC, trdb_pkg::SF_TRAP, branch, priv_i, cause_i,
                        interrupt_i, iaddr_i, tval_i};
    assign addr_f    = {trdb_pkg::F_ADDR_ONLY, iaddr_i};
    assign map_f     = {trdb_pkg::F_DIFF_DELTA, branches_i, branch_map_i};
    assign diff_f    = {map_f, diff_addr};

    always_comb begin
        payload_d = '0;
        len_d     = '0;
        addr_upd  = 1'b1;
        case (format_i)
            trdb_pkg::F_SYNC: begin
                case (subformat_i)
                    trdb_pkg::SF_START: begin
                        payload_d = trdb_pkg::payload_t'(start_f);
                        len_d     = bytes_of(trdb_pkg::START_W);
                    end
                    trdb_pkg::SF_TRAP: begin
                        payload_d = trdb_pkg::payload_t'(trap_f);
                        len_d     = bytes_of(trdb_pkg::TRAP_W);
                    end
                    trdb_pkg::SF_SUPPORT: begin
                        payload_d = trdb_pkg::payload_t'(support_f);
                        len_d     = bytes_of(trdb_pkg::SUPPORT_W);
                        addr_upd  = 1'b0;
                    end
                    default: addr_upd = 1'b0; // context subformat not generated
                endcase
            end
            trdb_pkg::F_ADDR_ONLY: begin
                payload_d = trdb_pkg::payload_t'(addr_f);
                len_d     = bytes_of(trdb_pkg::ADDR_W);
            end
            trdb_pkg::F_DIFF_DELTA: begin
                if (map_full_sel_i) begin // full map, no address
                    payload_d = trdb_pkg::payload_t'(map_f);
                    len_d     = bytes_of(trdb_pkg::MAP_W);
                    addr_upd  = 1'b0;
                end else begin
                    payload_d = trdb_pkg::payload_t'(diff_f);
                    len_d     = bytes_of(trdb_pkg::DIFF_W);
                end
            end
            default: addr_upd = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) packet_valid_o <= 1'b0;
        else packet_valid_o <= emit_i; // single cycle pulse, no back-pressure
    end

    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_format_o  <= format_i;
            packet_payload_o <= payload_d;
            payload_length_o <= len_d;
            if (addr_upd) last_addr_q <= iaddr_i;
        end
    end

endmodule

// ==== source/trdb_pkg.sv ====
// packet formats, encoder state and payload widths shared by all trace encoder blocks
package trdb_pkg;

    localparam int unsigned FMT_LEN     = 2; // format field width
    localparam int unsigned SUBFMT_LEN  = 2; // sync subformat field width
    localparam int unsigned QUAL_LEN    = 2;
    localparam int unsigned IOPT_LEN    = 3;
    localparam int unsigned PAYLOAD_LEN = 128; // widest payload vector
    localparam int unsigned P_LEN       = 5;   // length field, in bytes
    localparam int unsigned BMAP_LEN    = 31;  // branch map capacity
    localparam int unsigned BCOUNT_LEN  = 5;
    localparam int unsigned RESYNC_MAX  = 16;  // traced instructions between forced syncs
    localparam int unsigned RESYNC_CNT_LEN = $clog2(RESYNC_MAX);

    typedef enum logic [FMT_LEN-1:0] {
        F_OPT_EXT    = 2'd0, // not generated here
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } trdb_format_e;

    typedef enum logic [SUBFMT_LEN-1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_CONTEXT = 2'd2, // not generated here
        SF_SUPPORT = 2'd3
    } trdb_f_sync_subformat_e;

    typedef enum logic [QUAL_LEN-1:0] {
        NO_CHANGE  = 2'd0,
        ENDED_REP  = 2'd1,
        TRACE_LOST = 2'd2,
        ENDED_NTR  = 2'd3
    } qual_status_e;

    typedef logic [IOPT_LEN-1:0] ioptions_t;
    localparam ioptions_t DELTA_ADDRESS = 3'd1; // only mode supported

    typedef enum logic [1:0] {ST_IDLE, ST_SUPPORT, ST_START, ST_TRACE} trdb_state_e;

    typedef logic [PAYLOAD_LEN-1:0]    payload_t;
    typedef logic [P_LEN-1:0]          plen_t;
    typedef logic [BMAP_LEN-1:0]       bmap_t;
    typedef logic [BCOUNT_LEN-1:0]     bcount_t;
    typedef logic [RESYNC_CNT_LEN-1:0] resync_cnt_t;

    // field bit counts per packet, notime and nocontext both off
    localparam int unsigned SUPPORT_W = FMT_LEN + SUBFMT_LEN + 2 + QUAL_LEN + IOPT_LEN;
    localparam int unsigned START_W   = FMT_LEN + SUBFMT_LEN + 1 + trdb_cpu_pkg::PRIV_LEN
                                        + trdb_cpu_pkg::XLEN;
    localparam int unsigned TRAP_W    = START_W + trdb_cpu_pkg::CAUSE_LEN + 1
                                        + trdb_cpu_pkg::XLEN;
    localparam int unsigned ADDR_W    = FMT_LEN + trdb_cpu_pkg::XLEN;
    localparam int unsigned MAP_W     = FMT_LEN + BCOUNT_LEN + BMAP_LEN;
    localparam int unsigned DIFF_W    = MAP_W + trdb_cpu_pkg::XLEN;

endpackage

// ==== source/trdb_priority.sv ====
// encoder fsm, tracks trace enable and picks per retired instruction which packet goes out
`timescale 1ns/100ps

module trdb_priority (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            trace_enable_i,
    input  logic                            inst_valid_i,
    input  logic                            exception_i,
    input  logic                            interrupt_i,
    input  logic                            updiscon_i,
    input  logic                            resync_timeout_i,
    input  logic                            full_i,
    input  trdb_pkg::bcount_t               branches_i,
    output logic                            emit_o,        // one cycle per packet
    output trdb_pkg::trdb_format_e          format_o,
    output trdb_pkg::trdb_f_sync_subformat_e subformat_o,
    output logic                            map_full_sel_o, // format 1 without address
    output logic                            flush_o,
    output logic                            clear_o,
    output logic                            sync_sent_o
);

    trdb_pkg::trdb_state_e state_q, state_d;
    logic updiscon_q; // last valid instruction was an uninferable jump

    always_comb begin
        state_d        = state_q;
        emit_o         = 1'b0;
        format_o       = trdb_pkg::F_SYNC;
        subformat_o    = trdb_pkg::SF_START;
        map_full_sel_o = 1'b0;
        sync_sent_o    = 1'b0;
        case (state_q)
            trdb_pkg::ST_IDLE: begin
                if (trace_enable_i) state_d = trdb_pkg::ST_SUPPORT;
            end
            trdb_pkg::ST_SUPPORT: begin // announce encoder options, instruction ignored
                emit_o      = 1'b1;
                subformat_o = trdb_pkg::SF_SUPPORT;
                state_d     = trdb_pkg::ST_START;
            end
            trdb_pkg::ST_START: begin
                if (inst_valid_i) begin // first traced instruction always syncs
                    emit_o      = 1'b1;
                    sync_sent_o = 1'b1;
                    state_d     = trdb_pkg::ST_TRACE;
                end
            end
            trdb_pkg::ST_TRACE: begin
                if (inst_valid_i) begin
                    if (exception_i || interrupt_i) begin
                        emit_o      = 1'b1;
                        subformat_o = trdb_pkg::SF_TRAP;
                        sync_sent_o = 1'b1;
                    end else if (resync_timeout_i) begin // periodic start packet
                        emit_o      = 1'b1;
                        sync_sent_o = 1'b1;
                    end else if (updiscon_q) begin
                        // pending branches ride along with a delta, else full address
                        emit_o   = 1'b1;
                        format_o = (branches_i != '0) ? trdb_pkg::F_DIFF_DELTA
                                                      : trdb_pkg::F_ADDR_ONLY;
                    end else if (full_i) begin
                        emit_o         = 1'b1;
                        format_o       = trdb_pkg::F_DIFF_DELTA;
                        map_full_sel_o = 1'b1;
                    end
                end
            end
            default: state_d = trdb_pkg::ST_IDLE;
        endcase
        if (!trace_enable_i) begin // disable wins over everything
            state_d     = trdb_pkg::ST_IDLE;
            emit_o      = 1'b0;
            sync_sent_o = 1'b0;
        end
    end

    assign flush_o = emit_o && (state_q != trdb_pkg::ST_SUPPORT); // support keeps the map
    assign clear_o = !trace_enable_i || (state_q == trdb_pkg::ST_IDLE)
                     || (state_q == trdb_pkg::ST_SUPPORT); // nothing traced yet

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= trdb_pkg::ST_IDLE;
            updiscon_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (clear_o) updiscon_q <= 1'b0;
            else if (inst_valid_i) updiscon_q <= updiscon_i; // held across invalid cycles
        end
    end

endmodule

// ==== source/trdb_resync_cnt.sv ====
// counts traced instructions since the last sync packet and requests a periodic resync
`timescale 1ns/100ps

module trdb_resync_cnt (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic count_en_i,  // valid instruction this cycle
    input  logic sync_sent_i, // start or trap packet restarts the count
    input  logic clear_i,     // tracing off or not yet started
    output logic resync_timeout_o
);

    trdb_pkg::resync_cnt_t cnt_q;

    // raised on the RESYNC_MAX-th instruction, the fsm consumes it as a sync
    assign resync_timeout_o = count_en_i
                              && (cnt_q == trdb_pkg::resync_cnt_t'(trdb_pkg::RESYNC_MAX - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i || sync_sent_i) begin
            cnt_q <= '0;
        end else if (count_en_i && !resync_timeout_o) begin
            cnt_q <= cnt_q + 1'b1; // saturates at the limit if the timeout is not taken
        end
    end

endmodule

// ==== source/trdb_top.sv ====
// trace encoder top, hooks the cpu retirement ports to the packet output through the blocks
`timescale 1ns/100ps

module trdb_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   trace_enable_i,
    input  logic                   inst_valid_i,
    input  trdb_cpu_pkg::iaddr_t   iaddr_i,
    input  logic                   is_branch_i,
    input  logic                   is_branch_taken_i,
    input  logic                   exception_i,
    input  logic                   interrupt_i,
    input  trdb_cpu_pkg::cause_t   cause_i,
    input  trdb_cpu_pkg::tval_t    tval_i,
    input  trdb_cpu_pkg::priv_t    priv_i,
    input  logic                   updiscon_i,
    input  trdb_pkg::qual_status_e qual_status_i,
    output logic                   packet_valid_o,
    output trdb_pkg::trdb_format_e packet_format_o,
    output trdb_pkg::payload_t     packet_payload_o,
    output trdb_pkg::plen_t        payload_length_o
);

    logic                             emit, map_full_sel, flush, clear, sync_sent;
    logic                             full, resync_timeout;
    trdb_pkg::trdb_format_e           format;
    trdb_pkg::trdb_f_sync_subformat_e subformat;
    trdb_pkg::bcount_t                branches;
    trdb_pkg::bmap_t                  branch_map;

    trdb_priority i_trdb_priority (
        .clk_i, .rst_n_i, .trace_enable_i, .inst_valid_i, .exception_i, .interrupt_i,
        .updiscon_i, .resync_timeout_i(resync_timeout), .full_i(full),
        .branches_i(branches), .emit_o(emit), .format_o(format), .subformat_o(subformat),
        .map_full_sel_o(map_full_sel), .flush_o(flush), .clear_o(clear),
        .sync_sent_o(sync_sent)
    );

    trdb_resync_cnt i_trdb_resync_cnt (
        .clk_i, .rst_n_i, .count_en_i(inst_valid_i), .sync_sent_i(sync_sent),
        .clear_i(clear), .resync_timeout_o(resync_timeout)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_i, .rst_n_i, .inst_valid_i, .is_branch_i, .is_branch_taken_i,
        .flush_i(flush), .clear_i(clear), .branches_o(branches),
        .branch_map_o(branch_map), .full_o(full)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i, .rst_n_i, .emit_i(emit), .format_i(format), .subformat_i(subformat),
        .map_full_sel_i(map_full_sel), .iaddr_i, .priv_i, .cause_i, .tval_i, .interrupt_i,
        .is_branch_i, .is_branch_taken_i, .branches_i(branches), .branch_map_i(branch_map),
        .qual_status_i, .packet_valid_o, .packet_format_o, .packet_payload_o,
        .payload_length_o
    );

endmodule

// ==== trdb.f ====
source/trdb_cpu_pkg.sv
source/trdb_pkg.sv
source/trdb_priority.sv
source/trdb_resync_cnt.sv
source/trdb_branch_map.sv
source/trdb_packet_emitter.sv
source/trdb_top.sv
verification/trdb_checker.sv
verification/trdb_assert.sv
verification/trdb_tb.sv

// ==== verification/trdb_assert.sv ====
// output protocol assertions for the trace encoder top, attached by bind
`timescale 1ns/100ps

module trdb_assert (
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            trace_enable_i,
    input logic            inst_valid_i,
    input logic            emit_i,
    input logic            packet_valid_i,
    input trdb_pkg::plen_t payload_length_i
);

    // a packet needs tracing enabled at its deciding edge
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        packet_valid_i |-> $past(trace_enable_i)) else $error("packet while disabled");

    // support is the only emit without an instruction, one pulse per enable
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (emit_i && !inst_valid_i) |=> packet_valid_i && !(emit_i && !inst_valid_i))
        else $error("support packet not a single pulse");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        packet_valid_i |-> (payload_length_i != '0)) else $error("zero length packet");

endmodule

bind trdb_top trdb_assert i_trdb_assert (
    .clk_i, .rst_n_i, .trace_enable_i, .inst_valid_i, .emit_i(emit),
    .packet_valid_i(packet_valid_o), .payload_length_i(payload_length_o)
);

// ==== verification/trdb_checker.sv ====
// watches the trace encoder outputs and compares each table row against its expected packet
`timescale 1ns/100ps

module trdb_checker (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   row_i,         // a table row was applied at this edge
    input  int                     idx_i,
    input  logic                   exp_pkt_i,     // row should produce a packet
    input  logic [1:0]             exp_fmt_i,
    input  trdb_pkg::plen_t        exp_len_i,
    input  trdb_pkg::payload_t     exp_payload_i,
    input  logic                   packet_valid_i,
    input  trdb_pkg::trdb_format_e packet_format_i,
    input  trdb_pkg::payload_t     packet_payload_i,
    input  trdb_pkg::plen_t        payload_length_i,
    output int                     pass_cnt_o,
    output int                     fail_cnt_o
);

    // one stage, the dut decides within the cycle and registers the packet at the next edge
    logic               row_q;
    logic               pkt_q;
    int                 idx_q;
    logic [1:0]         fmt_q;
    trdb_pkg::plen_t    len_q;
    trdb_pkg::payload_t pay_q;
    logic               ok;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) row_q <= 1'b0;
        else row_q <= row_i;
        pkt_q <= exp_pkt_i;
        idx_q <= idx_i;
        fmt_q <= exp_fmt_i;
        len_q <= exp_len_i;
        pay_q <= exp_payload_i;
    end

    // outputs settle after the edge, compare half a cycle later
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            pass_cnt_o = 0;
            fail_cnt_o = 0;
        end else if (row_q) begin
            ok = 1'b1;
            if (pkt_q != packet_valid_i) begin
                $display("row %0d: packet %s", idx_q, pkt_q ? "missing" : "not expected");
                ok = 1'b0;
            end else if (packet_valid_i) begin
                if (packet_format_i != fmt_q) begin
                    $display("[ERROR] %0t packet_format_o expected %0d got %0d", $time,
                             fmt_q, packet_format_i);
                    ok = 1'b0;
                end
                if (payload_length_i != len_q) begin
                    $display("[ERROR] %0t payload_length_o expected %0d got %0d", $time,
                             len_q, payload_length_i);
                    ok = 1'b0;
                end
                if (packet_payload_i != pay_q) begin
                    $display("[ERROR] %0t packet_payload_o expected %h got %h", $time,
                             pay_q, packet_payload_i);
                    ok = 1'b0;
                end
            end
            if (ok) pass_cnt_o++;
            else fail_cnt_o++;
            $display("row %0d %s", idx_q, ok ? "ok" : "failed");
        end else if (packet_valid_i) begin
            $display("packet seen at %0t outside any table row", $time);
            fail_cnt_o++;
        end
    end

endmodule

// ==== verification/trdb_tb.sv ====
// testbench for the trace encoder, applies a stimulus table and passes expected packets on
`timescale 1ns/100ps

module trdb_tb;

    localparam int K_NONE = 0, K_SUPPORT = 1, K_START = 2, K_TRAP = 3, K_ADDR = 4, K_DIFF = 5;
    // row control bits: en, valid, branch, taken, exception, interrupt, updiscon
    localparam logic [6:0] C_EN = 7'b1000000, C_INS = 7'b1100000, C_BR = 7'b1110000;
    localparam logic [6:0] C_UPD = 7'b1100001, C_BRUPD = 7'b1110001, C_EXC = 7'b1110100;
    localparam logic [6:0] C_IRQ = 7'b1100010, C_DIS = 7'b0110000, C_DEXC = 7'b0110100;

    logic clk_i, rst_n_i, en, valid, br, tk, exc, irq, upd, row, exp_pkt;
    trdb_cpu_pkg::iaddr_t   addr;
    trdb_cpu_pkg::iaddr_t   last_addr;  // address of the last sync or address packet
    trdb_cpu_pkg::cause_t   cause = 5'd2;
    trdb_cpu_pkg::tval_t    tval = 32'h0badf00d;
    trdb_cpu_pkg::priv_t    priv = 2'd3;
    trdb_pkg::qual_status_e qual = trdb_pkg::ENDED_REP;
    logic [1:0] exp_fmt, fmt_p;
    trdb_pkg::plen_t exp_len, len_p;
    trdb_pkg::payload_t exp_payload, pay_p;
    trdb_pkg::bmap_t trk_map;           // expected branch map
    trdb_pkg::bcount_t trk_cnt;
    logic valid_o;
    trdb_pkg::trdb_format_e fmt_o;
    trdb_pkg::payload_t payload_o;
    trdb_pkg::plen_t len_o;
    logic [6:0] row_ctl [64];
    int row_kind [64];
    int n_rows = 0, idx = 0, cycles = 0, pass_cnt, fail_cnt;

    function automatic trdb_pkg::plen_t byte_len(input int bits);
        return trdb_pkg::plen_t'((bits + 7) / 8);
    endfunction

    task automatic add_row(input logic [6:0] ctl, input int kind);
        row_ctl[n_rows] = ctl;
        row_ctl[n_rows][3] = ctl[4] & 1'($urandom % 2); // random outcome for branches
        row_kind[n_rows] = kind;
        n_rows++;
    endtask

    // expected packet from the encoder rules, map includes this row's branch
    task automatic predict(input int i);
        logic [6:0] c;
        trdb_pkg::bmap_t m;
        trdb_pkg::bcount_t n;
        trdb_cpu_pkg::iaddr_t a;
        logic b;
        c = row_ctl[i];
        m = trk_map;
        n = trk_cnt;
        a = 32'h8000_0000 + 32'(i * 4);
        b = !(c[4] && c[3]);
        if (c[6] && c[5] && c[4]) begin
            m[n] = !c[3];
            n = n + 1'b1;
        end
        pay_p = '0;
        case (row_kind[i])
            K_SUPPORT: pay_p[10:0] = {2'd3, 2'd3, 1'b1, 1'b0, 2'(qual), 3'd1};
            K_START:   pay_p[38:0] = {2'd3, 2'd0, b, priv, a};
            K_TRAP:    pay_p[76:0] = {2'd3, 2'd1, b, priv, cause, c[1], a, tval};
            K_ADDR:    pay_p[33:0] = {2'd2, a};
            K_DIFF:    pay_p[69:0] = {2'd1, n, m, a - last_addr};
            default:   pay_p = '0;
        endcase
        fmt_p = (row_kind[i] == K_ADDR) ? 2'd2 : (row_kind[i] == K_DIFF) ? 2'd1 : 2'd3;
        len_p = byte_len(row_kind[i] == K_SUPPORT ? 11 : row_kind[i] == K_START ? 39 :
                         row_kind[i] == K_TRAP ? 77 : row_kind[i] == K_ADDR ? 34 : 70);
        if (!c[6] || row_kind[i] != K_NONE) begin
            trk_map = '0; // cleared or flushed by the packet
            trk_cnt = '0;
        end else begin
            trk_map = m;
            trk_cnt = n;
        end
        if (row_kind[i] > K_SUPPORT) last_addr = a;
    endtask

    trdb_top i_trdb_top (
        .clk_i, .rst_n_i, .trace_enable_i(en), .inst_valid_i(valid), .iaddr_i(addr),
        .is_branch_i(br), .is_branch_taken_i(tk), .exception_i(exc), .interrupt_i(irq),
        .cause_i(cause), .tval_i(tval), .priv_i(priv), .updiscon_i(upd),
        .qual_status_i(qual), .packet_valid_o(valid_o), .packet_format_o(fmt_o),
        .packet_payload_o(payload_o), .payload_length_o(len_o)
    );

    trdb_checker i_checker (
        .clk_i, .rst_n_i, .row_i(row), .idx_i(idx), .exp_pkt_i(exp_pkt), .exp_fmt_i(exp_fmt),
        .exp_len_i(exp_len), .exp_payload_i(exp_payload), .packet_valid_i(valid_o),
        .packet_format_i(fmt_o), .packet_payload_i(payload_o), .payload_length_i(len_o),
        .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= n_rows + 16 + 50) begin // table length plus reset plus drain margin
            $display("timeout after %0d cycles, table did not complete", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h417c));
        {rst_n_i, en, valid, br, tk, exc, irq, upd, row, exp_pkt} = '0;
        {addr, last_addr, trk_map, trk_cnt, exp_fmt, exp_len, exp_payload} = '0;
        add_row(C_EN, K_NONE);       // enable edge seen in idle
        add_row(C_EN, K_SUPPORT);
        add_row(C_INS, K_START);
        add_row(C_UPD, K_NONE);
        add_row(C_INS, K_ADDR);      // no branches pending
        add_row(C_BR, K_NONE);
        add_row(C_BRUPD, K_NONE);
        add_row(C_BR, K_DIFF);       // delta against the format 2 address
        repeat (10) add_row(C_INS, K_NONE);
        add_row(C_INS, K_START);     // 16th instruction after sync
        add_row(C_EXC, K_TRAP);
        repeat (13) add_row(C_BR, K_NONE);
        add_row(C_BRUPD, K_NONE);
        add_row(C_BR, K_DIFF);
        add_row(C_BR, K_START);      // count restarted at the trap
        // a full map needs more branches than fit between forced syncs
        add_row(C_DEXC, K_NONE);     // exception while disabled gives no trap
        add_row(C_DIS, K_NONE);
        add_row(C_EN, K_NONE);
        add_row(C_EN, K_SUPPORT);
        add_row(C_INS, K_START);
        add_row(C_BR, K_NONE);
        add_row(C_IRQ, K_TRAP);      // interrupt bit set in the trap packet
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk_i);
            predict(i);
            {en, valid, br, tk, exc, irq, upd} <= row_ctl[i];
            addr <= 32'h8000_0000 + 32'(i * 4);
            row <= 1'b1;
            idx <= i;
            exp_pkt <= (row_kind[i] != K_NONE);
            exp_fmt <= fmt_p;
            exp_len <= len_p;
            exp_payload <= pay_p;
        end
        @(posedge clk_i);
        {en, valid, row} <= '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        $display("rows passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == n_rows) $display("Everything OK");
        else $display("Something failed");
        $finish;
    end

endmodule
